/* noc_pkg.sv */
package noc_pkg;

  // router port numbering, local port first
  typedef enum logic [2:0] {
    PORT_LOCAL = 3'd0,
    PORT_EAST  = 3'd1,
    PORT_WEST  = 3'd2,
    PORT_NORTH = 3'd3,
    PORT_SOUTH = 3'd4
  } port_t;

  localparam int NUM_PORTS = 5;

  // node id is {y, x}
  localparam int NODE_W = 2;
  localparam int X_BIT = 0;
  localparam int Y_BIT = 1;

  // 2x2 mesh
  localparam int NUM_NODES = 4;

  // flit is {dst, src, payload}
  // field lsb counted down from the flit width, so lsb index = FLIT_W - X_LSB
  localparam int DST_LSB = NODE_W;
  localparam int SRC_LSB = 2 * NODE_W;

endpackage

/* traffic_lfsr.sv */
`timescale 1ns/1ps

module traffic_lfsr import noc_pkg::*; #(
  parameter int PAYLOAD_W = 8,
  parameter int NODE_ID = 0,
  parameter logic [NODE_W+PAYLOAD_W-1:0] LFSR_SEED = 1
) (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            take,
  output logic [2*NODE_W+PAYLOAD_W-1:0]   flit
);

  localparam int LFSR_W = NODE_W + PAYLOAD_W;
  localparam int FLIT_W = 2 * NODE_W + PAYLOAD_W;

  // galois feedback masks, maximal length for 4..16 bits
  function automatic logic [LFSR_W-1:0] tap_mask(input int w);
    logic [LFSR_W-1:0] mask;
    case (w)
      4:  mask = LFSR_W'('hC);
      5:  mask = LFSR_W'('h14);
      6:  mask = LFSR_W'('h30);
      7:  mask = LFSR_W'('h60);
      8:  mask = LFSR_W'('hB8);
      9:  mask = LFSR_W'('h110);
      10: mask = LFSR_W'('h240);
      11: mask = LFSR_W'('h500);
      12: mask = LFSR_W'('h829);
      13: mask = LFSR_W'('h100D);
      14: mask = LFSR_W'('h2015);
      15: mask = LFSR_W'('h6000);
      16: mask = LFSR_W'('hD008);
      default:
      begin
        // top two bits only, period not maximal
        mask = '0;
        mask[w-1] = 1'b1;
        mask[w-2] = 1'b1;
      end
    endcase
    return mask;
  endfunction

  localparam logic [LFSR_W-1:0] TAPS = tap_mask(LFSR_W);

  logic [LFSR_W-1:0] state;

  // right shift, fold lsb back through the taps
  always_ff @(posedge clk)
  begin
    if (rst)
      state <= LFSR_SEED;
    else if (take)
      state <= (state >> 1) ^ (state[0] ? TAPS : '0);
  end

  // low bits pick the destination, rest is payload
  always_comb
  begin
    flit = '0;
    flit[FLIT_W-DST_LSB +: NODE_W] = state[NODE_W-1:0];
    flit[FLIT_W-SRC_LSB +: NODE_W] = NODE_W'(NODE_ID);
    flit[PAYLOAD_W-1:0] = state[LFSR_W-1:NODE_W];
  end

  // a zero seed would lock the generator
  a_state_nonzero: assert property (@(posedge clk) disable iff (rst) state != '0);

endmodule

/* flit_fifo.sv */
`timescale 1ns/1ps

module flit_fifo #(
  parameter int FLIT_W = 12,
  parameter int FIFO_DEPTH = 4
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              push,
  input  logic              pop,
  input  logic [FLIT_W-1:0] din,
  output logic [FLIT_W-1:0] dout,
  output logic              empty,
  output logic              almost_full
);

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  logic [FLIT_W-1:0] mem [FIFO_DEPTH];
  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  logic [CNT_W-1:0]  count;

  // wrap for depths that are not a power of two
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
    return (p == PTR_W'(FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (push)
        wr_ptr <= ptr_inc(wr_ptr);
      if (pop)
        rd_ptr <= ptr_inc(rd_ptr);
      // count moves only when push and pop differ
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (push)
      mem[wr_ptr] <= din;
  end

  // head flit always visible
  assign dout = mem[rd_ptr];
  assign empty = (count == '0);
  // one free slot or fewer
  assign almost_full = (count >= CNT_W'(FIFO_DEPTH - 1));

  // upstream stall must keep the queue from overrunning
  a_no_overflow: assert property (@(posedge clk) disable iff (rst)
    push |-> (count != CNT_W'(FIFO_DEPTH)));
  a_no_underflow: assert property (@(posedge clk) disable iff (rst)
    pop |-> !empty);

endmodule

/* rr_output_arbiter.sv */
`timescale 1ns/1ps

module rr_output_arbiter import noc_pkg::*; (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 advance,
  input  logic [NUM_PORTS-1:0] req,
  output logic [NUM_PORTS-1:0] grant
);

  // last input that won this output
  port_t last;
  port_t win;

  // scan starts one past the last winner and wraps
  always_comb
  begin
    grant = '0;
    win = last;
    for (int k = 1; k <= NUM_PORTS; k++)
    begin
      if (grant == '0 && req[(int'(last) + k) % NUM_PORTS])
      begin
        grant[(int'(last) + k) % NUM_PORTS] = 1'b1;
        win = port_t'((int'(last) + k) % NUM_PORTS);
      end
    end
  end

  // pointer moves only when the output really takes the flit
  always_ff @(posedge clk)
  begin
    if (rst)
      last <= PORT_SOUTH;
    else if (advance)
      last <= win;
  end

  a_grant_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(grant));

  // router fires an output only for a granted requester
  a_advance_granted: assert property (@(posedge clk) disable iff (rst)
    advance |-> ((grant & req) != '0));

endmodule

/* mesh_router.sv */
`timescale 1ns/1ps

module mesh_router import noc_pkg::*; #(
  parameter int FLIT_W = 12,
  parameter int FIFO_DEPTH = 4,
  parameter int NODE_ID = 0
) (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              write,
  input  logic                              read,
  input  logic [NUM_PORTS-1:0][FLIT_W-1:0]  in_flit,
  input  logic [NUM_PORTS-1:0]              in_valid,
  input  logic [NUM_PORTS-1:0]              out_stall,
  output logic                              local_take,
  output logic [NUM_PORTS-1:0]              in_stall,
  output logic [NUM_PORTS-1:0][FLIT_W-1:0]  out_flit,
  output logic [NUM_PORTS-1:0]              out_valid
);

  localparam logic [NODE_W-1:0] MY_ID = NODE_W'(NODE_ID);

  logic [NUM_PORTS-1:0][FLIT_W-1:0] head;
  logic [NUM_PORTS-1:0]             push;
  logic [NUM_PORTS-1:0]             pop;
  logic [NUM_PORTS-1:0]             empty;
  logic [NUM_PORTS-1:0]             almost_full;
  port_t                            route [NUM_PORTS];
  // req[o][i] and grant[o][i], output o by input i
  logic [NUM_PORTS-1:0]             req [NUM_PORTS];
  logic [NUM_PORTS-1:0]             grant [NUM_PORTS];
  logic [NUM_PORTS-1:0][FLIT_W-1:0] win_flit;
  logic [NUM_PORTS-1:0]             blocked;
  logic [NUM_PORTS-1:0]             fire;
  logic [NUM_PORTS-1:0]             obuf_valid;
  logic [NUM_PORTS-1:0][FLIT_W-1:0] obuf;

  // x first, then y; y grows southward
  function automatic port_t xy_route(input logic [NODE_W-1:0] dst);
    port_t dir;
    if (dst[X_BIT] != MY_ID[X_BIT])
      dir = dst[X_BIT] ? PORT_EAST : PORT_WEST;
    else if (dst[Y_BIT] != MY_ID[Y_BIT])
      dir = dst[Y_BIT] ? PORT_SOUTH : PORT_NORTH;
    else
      dir = PORT_LOCAL;
    return dir;
  endfunction

  // source injects while write is up and the local queue has room
  assign local_take = write & in_valid[PORT_LOCAL] & ~almost_full[PORT_LOCAL];
  assign in_stall = almost_full;

  always_comb
  begin
    push = in_valid;
    push[PORT_LOCAL] = local_take;
  end

  for (genvar i = 0; i < NUM_PORTS; i++)
  begin : g_in
    flit_fifo #(
      .FLIT_W     (FLIT_W),
      .FIFO_DEPTH (FIFO_DEPTH)
    ) u_queue (
      .clk         (clk),
      .rst         (rst),
      .push        (push[i]),
      .pop         (pop[i]),
      .din         (in_flit[i]),
      .dout        (head[i]),
      .empty       (empty[i]),
      .almost_full (almost_full[i])
    );
  end

  // only queue heads request
  always_comb
  begin
    for (int i = 0; i < NUM_PORTS; i++)
      route[i] = xy_route(head[i][FLIT_W-DST_LSB +: NODE_W]);
    for (int o = 0; o < NUM_PORTS; o++)
    begin
      for (int i = 0; i < NUM_PORTS; i++)
        req[o][i] = ~empty[i] & (route[i] == port_t'(o));
    end
  end

  // local output waits for read, link outputs for downstream stall
  assign blocked = {out_stall[NUM_PORTS-1:1], ~read | out_stall[PORT_LOCAL]};

  for (genvar o = 0; o < NUM_PORTS; o++)
  begin : g_out
    // load when the register is empty or drains this cycle
    assign fire[o] = (|req[o]) & (~obuf_valid[o] | ~blocked[o]);

    rr_output_arbiter u_arb (
      .clk     (clk),
      .rst     (rst),
      .advance (fire[o]),
      .req     (req[o]),
      .grant   (grant[o])
    );

    // presented only while not stalled, held otherwise
    assign out_valid[o] = obuf_valid[o] & ~blocked[o];
    assign out_flit[o] = obuf[o];
  end

  // one-hot grant selects the winning head
  always_comb
  begin
    pop = '0;
    for (int o = 0; o < NUM_PORTS; o++)
    begin
      win_flit[o] = '0;
      for (int i = 0; i < NUM_PORTS; i++)
      begin
        if (grant[o][i])
          win_flit[o] = win_flit[o] | head[i];
        pop[i] = pop[i] | (fire[o] & grant[o][i]);
      end
    end
  end

  always_ff @(posedge clk)
  begin
    for (int o = 0; o < NUM_PORTS; o++)
    begin
      if (rst)
        obuf_valid[o] <= 1'b0;
      else if (fire[o])
        obuf_valid[o] <= 1'b1;
      else if (!blocked[o])
        obuf_valid[o] <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    for (int o = 0; o < NUM_PORTS; o++)
    begin
      if (fire[o])
        obuf[o] <= win_flit[o];
    end
  end

endmodule

/* mesh_2x2.sv */
`timescale 1ns/1ps

module mesh_2x2 import noc_pkg::*; #(
  parameter int PAYLOAD_W = 8,
  parameter int FIFO_DEPTH = 4,
  parameter logic [NODE_W+PAYLOAD_W-1:0] SEED00 = 'h1A5,
  parameter logic [NODE_W+PAYLOAD_W-1:0] SEED01 = 'h2C3,
  parameter logic [NODE_W+PAYLOAD_W-1:0] SEED10 = 'h0F1,
  parameter logic [NODE_W+PAYLOAD_W-1:0] SEED11 = 'h35E,
  localparam int FLIT_W = 2 * NODE_W + PAYLOAD_W
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              write,
  input  logic              read,
  output logic [FLIT_W-1:0] local_out00,
  output logic [FLIT_W-1:0] local_out01,
  output logic [FLIT_W-1:0] local_out10,
  output logic [FLIT_W-1:0] local_out11,
  output logic              local_valid00,
  output logic              local_valid01,
  output logic              local_valid10,
  output logic              local_valid11,
  output logic              inject00,
  output logic              inject01,
  output logic              inject10,
  output logic              inject11
);

  localparam logic [NODE_W+PAYLOAD_W-1:0] SEEDS [NUM_NODES] = '{SEED00, SEED01, SEED10, SEED11};

  logic [FLIT_W-1:0]                src_flit [NUM_NODES];
  logic [NUM_NODES-1:0]             take;
  logic [NUM_PORTS-1:0][FLIT_W-1:0] r_in_flit [NUM_NODES];
  logic [NUM_PORTS-1:0][FLIT_W-1:0] r_out_flit [NUM_NODES];
  logic [NUM_PORTS-1:0]             r_in_valid [NUM_NODES];
  logic [NUM_PORTS-1:0]             r_out_valid [NUM_NODES];
  logic [NUM_PORTS-1:0]             r_in_stall [NUM_NODES];
  logic [NUM_PORTS-1:0]             r_out_stall [NUM_NODES];
  // registered link stage, indexed by receiving node and port
  logic [NUM_PORTS-1:0][FLIT_W-1:0] link_flit [NUM_NODES];
  logic [NUM_PORTS-1:0]             link_valid [NUM_NODES];

  // edge ports have no neighbor; node id bit 0 is x, bit 1 is y
  function automatic logic has_link(input int n, input int p);
    logic ok;
    case (p)
      PORT_EAST:  ok = ((n & 1) == 0);
      PORT_WEST:  ok = ((n & 1) == 1);
      PORT_NORTH: ok = ((n & 2) == 2);
      PORT_SOUTH: ok = ((n & 2) == 0);
      default:    ok = 1'b0;
    endcase
    return ok;
  endfunction

  function automatic int link_peer(input int n, input int p);
    return (p == PORT_EAST || p == PORT_WEST) ? (n ^ 1) : (n ^ 2);
  endfunction

  function automatic int opposite(input int p);
    int q;
    case (p)
      PORT_EAST:  q = PORT_WEST;
      PORT_WEST:  q = PORT_EAST;
      PORT_NORTH: q = PORT_SOUTH;
      PORT_SOUTH: q = PORT_NORTH;
      default:    q = PORT_LOCAL;
    endcase
    return q;
  endfunction

  // flit and valid cross one register; edge links stay idle
  always_ff @(posedge clk)
  begin
    for (int n = 0; n < NUM_NODES; n++)
    begin
      for (int p = 1; p < NUM_PORTS; p++)
      begin
        if (rst || !has_link(n, p))
          link_valid[n][p] <= 1'b0;
        else
          link_valid[n][p] <= r_out_valid[link_peer(n, p)][opposite(p)];
        link_flit[n][p] <= has_link(n, p) ? r_out_flit[link_peer(n, p)][opposite(p)] : '0;
      end
    end
  end

  // stall returns combinationally; edge outputs held stalled
  always_comb
  begin
    for (int n = 0; n < NUM_NODES; n++)
    begin
      r_in_flit[n][PORT_LOCAL] = src_flit[n];
      r_in_valid[n][PORT_LOCAL] = 1'b1;
      r_out_stall[n][PORT_LOCAL] = 1'b0;
      for (int p = 1; p < NUM_PORTS; p++)
      begin
        r_in_flit[n][p] = link_flit[n][p];
        r_in_valid[n][p] = link_valid[n][p];
        r_out_stall[n][p] = has_link(n, p) ? r_in_stall[link_peer(n, p)][opposite(p)] : 1'b1;
      end
    end
  end

  for (genvar n = 0; n < NUM_NODES; n++)
  begin : g_node
    traffic_lfsr #(
      .PAYLOAD_W (PAYLOAD_W),
      .NODE_ID   (n),
      .LFSR_SEED (SEEDS[n])
    ) u_src (
      .clk  (clk),
      .rst  (rst),
      .take (take[n]),
      .flit (src_flit[n])
    );

    mesh_router #(
      .FLIT_W     (FLIT_W),
      .FIFO_DEPTH (FIFO_DEPTH),
      .NODE_ID    (n)
    ) u_router (
      .clk        (clk),
      .rst        (rst),
      .write      (write),
      .read       (read),
      .in_flit    (r_in_flit[n]),
      .in_valid   (r_in_valid[n]),
      .out_stall  (r_out_stall[n]),
      .local_take (take[n]),
      .in_stall   (r_in_stall[n]),
      .out_flit   (r_out_flit[n]),
      .out_valid  (r_out_valid[n])
    );
  end

  // node 01 is x1 y0, index 1
  assign local_out00 = r_out_flit[0][PORT_LOCAL];
  assign local_out01 = r_out_flit[1][PORT_LOCAL];
  assign local_out10 = r_out_flit[2][PORT_LOCAL];
  assign local_out11 = r_out_flit[3][PORT_LOCAL];
  assign local_valid00 = r_out_valid[0][PORT_LOCAL];
  assign local_valid01 = r_out_valid[1][PORT_LOCAL];
  assign local_valid10 = r_out_valid[2][PORT_LOCAL];
  assign local_valid11 = r_out_valid[3][PORT_LOCAL];
  assign inject00 = take[0];
  assign inject01 = take[1];
  assign inject10 = take[2];
  assign inject11 = take[3];

endmodule

/* tb_mesh_2x2.sv */
`timescale 1ns/1ps

module tb_mesh_2x2 import noc_pkg::*; ();

  localparam int PAYLOAD_W = 8;
  localparam int FIFO_DEPTH = 4;
  localparam int FLIT_W = 2 * NODE_W + PAYLOAD_W;
  localparam int LFSR_W = NODE_W + PAYLOAD_W;
  localparam int CLK_PERIOD = 100;
  localparam int RESET_CYCLES = 3;

  // cycle budgets per test
  localparam int QUIET_CYCLES = 20;
  localparam int DELIVERY_CYCLES = 300;
  localparam int LOOPBACK_CYCLES = 100;
  localparam int STALL_FILL = 150;
  localparam int STALL_HOLD = 50;
  localparam int RANDOM_CYCLES = 1000;
  localparam int DRAIN_BUDGET = 300;
  localparam int WATCHDOG_CYCLES = RESET_CYCLES + QUIET_CYCLES + DELIVERY_CYCLES
    + LOOPBACK_CYCLES + STALL_FILL + STALL_HOLD + RANDOM_CYCLES + 4 * DRAIN_BUDGET + 100;

  // galois taps for a 10 bit maximal sequence
  localparam logic [LFSR_W-1:0] LFSR_TAPS = 10'h240;
  localparam logic [LFSR_W-1:0] SEEDS [NUM_NODES] = '{10'h1A5, 10'h2C3, 10'h0F1, 10'h35E};
  localparam logic [31:0] LCG_SEED = 32'h15b1_ef4b;

  logic clk;
  logic rst;
  logic write;
  logic read;
  logic [FLIT_W-1:0]    eject_flit [NUM_NODES];
  logic [NUM_NODES-1:0] eject_valid;
  logic [NUM_NODES-1:0] inject;

  // model state and scoreboard, keyed by src * 4 + dst
  logic [LFSR_W-1:0] model_state [NUM_NODES];
  logic [FLIT_W-1:0] exp_q [NUM_NODES*NUM_NODES][$];
  int inject_total = 0;
  int eject_total = 0;
  int loopback_count = 0;
  int error_count = 0;
  int test_num = 0;
  int base_inject;
  int base_eject;
  int base_err;

  mesh_2x2 #(
    .PAYLOAD_W  (PAYLOAD_W),
    .FIFO_DEPTH (FIFO_DEPTH),
    .SEED00     (SEEDS[0]),
    .SEED01     (SEEDS[1]),
    .SEED10     (SEEDS[2]),
    .SEED11     (SEEDS[3])
  ) dut0 (
    .clk           (clk),
    .rst           (rst),
    .write         (write),
    .read          (read),
    .local_out00   (eject_flit[0]),
    .local_out01   (eject_flit[1]),
    .local_out10   (eject_flit[2]),
    .local_out11   (eject_flit[3]),
    .local_valid00 (eject_valid[0]),
    .local_valid01 (eject_valid[1]),
    .local_valid10 (eject_valid[2]),
    .local_valid11 (eject_valid[3]),
    .inject00      (inject[0]),
    .inject01      (inject[1]),
    .inject10      (inject[2]),
    .inject11      (inject[3])
  );

  // right shift, lsb folds back through the taps
  function automatic logic [LFSR_W-1:0] lfsr_next(input logic [LFSR_W-1:0] s);
    return (s >> 1) ^ (s[0] ? LFSR_TAPS : '0);
  endfunction

  // {dst, src, payload}; dst from low state bits
  function automatic logic [FLIT_W-1:0] expected_flit(input int node, input logic [LFSR_W-1:0] s);
    return {s[NODE_W-1:0], NODE_W'(node), s[LFSR_W-1:NODE_W]};
  endfunction

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // predict on inject, compare on eject
  always @(posedge clk)
  begin : scoreboard
    int key;
    int src;
    logic [FLIT_W-1:0] want;
    logic [FLIT_W-1:0] got;
    if (rst)
    begin
      for (int n = 0; n < NUM_NODES; n++)
        model_state[n] = SEEDS[n];
      for (int k = 0; k < NUM_NODES * NUM_NODES; k++)
        exp_q[k].delete();
    end
    else
    begin
      // inject pulse takes the flit shown this cycle
      for (int n = 0; n < NUM_NODES; n++)
      begin
        if (inject[n])
        begin
          want = expected_flit(n, model_state[n]);
          key = n * NUM_NODES + int'(want[FLIT_W-1 -: NODE_W]);
          exp_q[key].push_back(want);
          model_state[n] = lfsr_next(model_state[n]);
          inject_total++;
        end
      end
      for (int n = 0; n < NUM_NODES; n++)
      begin
        if (eject_valid[n])
        begin
          got = eject_flit[n];
          src = int'(got[FLIT_W-NODE_W-1 -: NODE_W]);
          key = src * NUM_NODES + n;
          eject_total++;
          // dst field must name the ejecting node
          if (int'(got[FLIT_W-1 -: NODE_W]) != n)
          begin
            $display("[ERROR] %0t ns: node %0d ejected flit %h addressed to node %0d",
                     $time, n, got, got[FLIT_W-1 -: NODE_W]);
            error_count++;
          end
          else if (exp_q[key].size() == 0)
          begin
            $display("[ERROR] %0t ns: node %0d ejected flit %h, none expected from node %0d",
                     $time, n, got, src);
            error_count++;
          end
          else
          begin
            want = exp_q[key].pop_front();
            if (got != want)
            begin
              $display("[ERROR] %0t ns: node %0d expected flit %h, received %h",
                       $time, n, want, got);
              error_count++;
            end
            if (src == n)
              loopback_count++;
          end
        end
      end
    end
  end

  task automatic mark_test_start();
    test_num++;
    base_inject = inject_total;
    base_eject = eject_total;
    base_err = error_count;
  endtask

  task automatic report_test(input string name);
    $display("test %0d %s: %s, %0d injected, %0d ejected", test_num, name,
             (error_count == base_err) ? "pass" : "FAIL",
             inject_total - base_inject, eject_total - base_eject);
  endtask

  // stop sources, open outputs, wait until every flit is out
  // or the drain budget runs out
  task automatic drain_network();
    int waited;
    write = 1'b0;
    read = 1'b1;
    waited = 0;
    while (eject_total < inject_total && waited < DRAIN_BUDGET)
    begin
      @(negedge clk);
      waited++;
    end
    repeat (5) @(negedge clk);
  endtask

  task automatic check_scoreboard_empty();
    int left;
    left = 0;
    for (int k = 0; k < NUM_NODES * NUM_NODES; k++)
      left += exp_q[k].size();
    if (left != 0)
    begin
      $display("[ERROR] %0t ns: %0d predicted flits were never ejected", $time, left);
      error_count++;
    end
  endtask

  initial
  begin
    int base_loop;
    int hold_inject;
    logic [31:0] rng;
    rst = 1'b1;
    write = 1'b0;
    read = 1'b0;
    repeat (RESET_CYCLES) @(negedge clk);
    rst = 1'b0;

    // nothing moves with both strobes low
    mark_test_start();
    repeat (QUIET_CYCLES) @(negedge clk);
    if (inject_total != base_inject)
    begin
      $display("[ERROR] %0t ns: a source injected while write was low", $time);
      error_count++;
    end
    if (eject_total != base_eject)
    begin
      $display("[ERROR] %0t ns: a node ejected while read was low", $time);
      error_count++;
    end
    report_test("reset quiet");

    // full rate traffic, then drain
    mark_test_start();
    write = 1'b1;
    read = 1'b1;
    repeat (DELIVERY_CYCLES) @(negedge clk);
    drain_network();
    check_scoreboard_empty();
    if (inject_total == base_inject)
    begin
      $display("[ERROR] %0t ns: no flit was injected with write high", $time);
      error_count++;
    end
    report_test("delivery");

    // self-addressed flits come back at the source node
    mark_test_start();
    base_loop = loopback_count;
    write = 1'b1;
    read = 1'b1;
    repeat (LOOPBACK_CYCLES) @(negedge clk);
    drain_network();
    check_scoreboard_empty();
    $display("loopback flits ejected: %0d", loopback_count - base_loop);
    if (loopback_count == base_loop)
    begin
      $display("[ERROR] %0t ns: no self-addressed flit was ejected", $time);
      error_count++;
    end
    report_test("loopback");

    // read low, queues fill and sources must stop
    mark_test_start();
    write = 1'b1;
    read = 1'b0;
    repeat (STALL_FILL) @(negedge clk);
    hold_inject = inject_total;
    repeat (STALL_HOLD) @(negedge clk);
    if (inject_total != hold_inject)
    begin
      $display("[ERROR] %0t ns: sources kept injecting with every output stalled", $time);
      error_count++;
    end
    if (eject_total != base_eject)
    begin
      $display("[ERROR] %0t ns: a flit was ejected while read was low", $time);
      error_count++;
    end
    drain_network();
    check_scoreboard_empty();
    report_test("back-pressure");

    // random strobes from the lcg
    mark_test_start();
    rng = LCG_SEED;
    for (int c = 0; c < RANDOM_CYCLES; c++)
    begin
      rng = lcg_next(rng);
      write = rng[16];
      read = rng[24];
      @(negedge clk);
    end
    drain_network();
    check_scoreboard_empty();
    if (inject_total - base_inject != eject_total - base_eject)
    begin
      $display("[ERROR] %0t ns: %0d injected but %0d ejected", $time,
               inject_total - base_inject, eject_total - base_eject);
      error_count++;
    end
    report_test("random strobes");

    $display("tests run: %0d, failed checks: %0d, flits injected: %0d, ejected: %0d",
             test_num, error_count, inject_total, eject_total);
    if (error_count == 0)
      $display("No errors");
    else
      $display("Errors found");
    $finish;
  end

  // bound on the whole run, drains included
  initial
  begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("timeout: the network did not drain within %0d cycles", WATCHDOG_CYCLES);
    $display("Errors found");
    $finish;
  end

endmodule

/* build.f */
noc_pkg.sv
traffic_lfsr.sv
flit_fifo.sv
rr_output_arbiter.sv
mesh_router.sv
mesh_2x2.sv
tb_mesh_2x2.sv

/* run_sim.sh */
#!/bin/sh
# build and run the 2x2 mesh testbench with verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f build.f --top-module tb_mesh_2x2 -o sim_mesh
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/sim_mesh > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

# the log decides pass or fail
if grep -q "Errors found" "$LOG"; then
  echo "simulation reported failure"
  exit 1
fi
echo "simulation passed"
exit 0
